// ==== src/cap_pkg.sv ====
/*
 * Capture buffer package.
 * Sizes, bus address map and vector types that are shared by
 * the stream channels, the arbiter, the sample RAM and the bus slave.
 */

`default_nettype none

package cap_pkg;

  ////////////////////
  // sizes
  ////////////////////

  // stream sample width
  localparam int smp_w = 16;
  // one channel segment, 64 words
  localparam int seg_aw = 6;
  // whole RAM, top bit picks the channel
  localparam int ram_aw = seg_aw + 1;
  // credits per source, also the queue depth
  localparam int credit_max = 4;
  localparam int q_aw = $clog2(credit_max);

  typedef logic [smp_w-1:0]  smp_t;
  typedef logic [ram_aw-1:0] ram_addr_t;
  typedef logic [seg_aw-1:0] seg_addr_t;
  typedef logic [11:0]       bus_addr_t;
  typedef logic [31:0]       bus_data_t;

  ////////////////////
  // address map
  ////////////////////

  // RAM words 0x000..0x1fc, word index is addr>>2
  localparam bus_addr_t adr_ram_last = 12'h1fc;
  // per channel status, pointer in 5..0 and lap in 8
  localparam bus_addr_t adr_ptr0 = 12'h200;
  localparam bus_addr_t adr_ptr1 = 12'h204;
  // any write clears pointers and lap flags
  localparam bus_addr_t adr_ctl = 12'h208;

endpackage : cap_pkg

`default_nettype wire

// ==== src/cap_channel.sv ====
/*
 * Stream capture channel.
 * Accepts credit-controlled samples into a small queue, offers the
 * queue head to the write arbiter, and advances a wrapping segment
 * pointer with a sticky lap flag on every granted write.
 */

`timescale 1ns/100ps
`default_nettype none

module cap_channel #(
  // channel number, top RAM address bit
  parameter bit chan = 1'b0
) (
  input  logic                bus,
  input  logic                ctl_rst,
  // sample stream
  input  logic                str_valid,
  input  cap_pkg::smp_t       str_data,
  output logic                str_credit,
  // write arbiter side
  output logic                req,
  input  logic                gnt,
  output cap_pkg::smp_t       wdata,
  output cap_pkg::ram_addr_t  waddr,
  // status and software clear
  input  logic                clr,
  output cap_pkg::seg_addr_t  ptr,
  output logic                lap
);

  ////////////////////
  // sample queue
  ////////////////////

  cap_pkg::smp_t           q_mem [cap_pkg::credit_max];
  logic [cap_pkg::q_aw-1:0] q_wr;
  logic [cap_pkg::q_aw-1:0] q_rd;
  logic [cap_pkg::q_aw:0]   q_cnt;

  // no full check, credits bound the fill level
  always_ff @(posedge bus) begin
    if (str_valid) begin
      q_mem[q_wr] <= str_data;
    end
  end

  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      q_wr  <= '0;
      q_rd  <= '0;
      q_cnt <= '0;
    end else begin
      if (str_valid) begin
        q_wr <= q_wr + 1'b1;
      end
      if (gnt) begin
        q_rd <= q_rd + 1'b1;
      end
      // push and pop in one cycle keeps the count
      case ({str_valid, gnt})
        2'b10:   q_cnt <= q_cnt + 1'b1;
        2'b01:   q_cnt <= q_cnt - 1'b1;
        default: q_cnt <= q_cnt;
      endcase
    end
  end

  assign req   = (q_cnt != '0);
  assign wdata = q_mem[q_rd];

  // each write into RAM hands one credit back
  assign str_credit = gnt;

  ////////////////////
  // write pointer
  ////////////////////

  // during clear the granted sample already goes to the new base
  assign waddr = {chan, clr ? cap_pkg::seg_addr_t'(0) : ptr};

  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      ptr <= '0;
      lap <= 1'b0;
    end else if (clr) begin
      ptr <= cap_pkg::seg_addr_t'(gnt);
      lap <= 1'b0;
    end else if (gnt) begin
      ptr <= ptr + 1'b1;
      // sticky, segment was overwritten at least once
      if (ptr == '1) begin
        lap <= 1'b1;
      end
    end
  end

endmodule : cap_channel

`default_nettype wire

// ==== src/cap_arbiter.sv ====
/*
 * Round-robin write arbiter.
 * Grants the shared RAM write port to one of two channel queues per
 * cycle and registers the winning address and sample onto the port.
 */

`timescale 1ns/100ps
`default_nettype none

module cap_arbiter (
  input  logic                bus,
  input  logic                ctl_rst,
  // channel 0
  input  logic                req0,
  input  cap_pkg::smp_t       wdata0,
  input  cap_pkg::ram_addr_t  waddr0,
  output logic                gnt0,
  // channel 1
  input  logic                req1,
  input  cap_pkg::smp_t       wdata1,
  input  cap_pkg::ram_addr_t  waddr1,
  output logic                gnt1,
  // RAM write port
  output logic                ram_wen,
  output cap_pkg::ram_addr_t  ram_waddr,
  output cap_pkg::smp_t       ram_wdata
);

  // high when channel 1 won the last grant
  logic last;

  // contention goes to the channel that did not win last
  assign gnt0 = req0 & (~req1 | last);
  assign gnt1 = req1 & (~req0 | ~last);

  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      last    <= 1'b0;
      ram_wen <= 1'b0;
    end else begin
      ram_wen <= gnt0 | gnt1;
      if (gnt0 | gnt1) begin
        last <= gnt1;
      end
    end
  end

  ////////////////////
  // write port regs
  ////////////////////

  always_ff @(posedge bus) begin
    if (gnt1) begin
      ram_waddr <= waddr1;
      ram_wdata <= wdata1;
    end else begin
      ram_waddr <= waddr0;
      ram_wdata <= wdata0;
    end
  end

endmodule : cap_arbiter

`default_nettype wire

// ==== src/cap_ram.sv ====
/*
 * Shared sample RAM.
 * 128 words, one write port from the arbiter and one registered
 * read port for the bus slave.
 */

`timescale 1ns/100ps
`default_nettype none

module cap_ram (
  input  logic                bus,
  // write port
  input  logic                ram_wen,
  input  cap_pkg::ram_addr_t  ram_waddr,
  input  cap_pkg::smp_t       ram_wdata,
  // read port
  input  logic                rd_en,
  input  cap_pkg::ram_addr_t  rd_addr,
  output cap_pkg::smp_t       rd_data
);

  cap_pkg::smp_t mem [2**cap_pkg::ram_aw];

  always_ff @(posedge bus) begin
    if (ram_wen) begin
      mem[ram_waddr] <= ram_wdata;
    end
  end

  // old data on a same-address collision
  always_ff @(posedge bus) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule : cap_ram

`default_nettype wire

// ==== src/cap_bus_slave.sv ====
/*
 * System bus slave of the capture buffer.
 * Decodes RAM, status and control addresses, reads the sample RAM,
 * and answers every access two cycles after the request.
 */

`timescale 1ns/100ps
`default_nettype none

module cap_bus_slave (
  input  logic                bus,
  input  logic                ctl_rst,
  // system bus
  input  cap_pkg::bus_addr_t  bus_addr,
  input  cap_pkg::bus_data_t  bus_wdata,
  input  logic                bus_wen,
  input  logic                bus_ren,
  output cap_pkg::bus_data_t  bus_rdata,
  output logic                bus_ack,
  output logic                bus_err,
  // RAM read port
  output logic                rd_en,
  output cap_pkg::ram_addr_t  rd_addr,
  input  cap_pkg::smp_t       rd_data,
  // channel status
  input  cap_pkg::seg_addr_t  ptr0,
  input  cap_pkg::seg_addr_t  ptr1,
  input  logic                lap0,
  input  logic                lap1,
  output logic                clr
);

  logic               is_ram, is_ptr0, is_ptr1, is_ctl, is_map;
  logic               ack_s1, err_s1, ram_s1;
  cap_pkg::bus_data_t stat_s1;

  // pointer in 5..0 and lap in 8
  function automatic cap_pkg::bus_data_t stat_word(
    input cap_pkg::seg_addr_t p,
    input logic               l
  );
    stat_word = '0;
    stat_word[cap_pkg::seg_aw-1:0] = p;
    stat_word[8] = l;
  endfunction

  ////////////////////
  // address decode
  ////////////////////

  assign is_ram  = (bus_addr <= cap_pkg::adr_ram_last);
  assign is_ptr0 = (bus_addr == cap_pkg::adr_ptr0);
  assign is_ptr1 = (bus_addr == cap_pkg::adr_ptr1);
  assign is_ctl  = (bus_addr == cap_pkg::adr_ctl);
  assign is_map  = is_ram | is_ptr0 | is_ptr1 | is_ctl;

  // RAM samples at the request edge as the first read stage
  assign rd_en   = bus_ren & is_ram;
  assign rd_addr = bus_addr[cap_pkg::ram_aw+1:2];

  ////////////////////
  // stage 1
  ////////////////////

  // control write acts on the address alone
  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      ack_s1 <= 1'b0;
      err_s1 <= 1'b0;
      clr    <= 1'b0;
    end else begin
      ack_s1 <= bus_ren | bus_wen;
      err_s1 <= (bus_ren | bus_wen) & ~is_map;
      clr    <= bus_wen & is_ctl;
    end
  end

  // status taken at the request like the RAM word
  always_ff @(posedge bus) begin
    ram_s1 <= is_ram;
    if (is_ptr0) begin
      stat_s1 <= stat_word(ptr0, lap0);
    end else if (is_ptr1) begin
      stat_s1 <= stat_word(ptr1, lap1);
    end else begin
      stat_s1 <= '0;
    end
  end

  ////////////////////
  // stage 2
  ////////////////////

  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      bus_ack <= 1'b0;
      bus_err <= 1'b0;
    end else begin
      bus_ack <= ack_s1;
      bus_err <= err_s1;
    end
  end

  // sample zero-extended to the bus word
  always_ff @(posedge bus) begin
    bus_rdata <= ram_s1 ? cap_pkg::bus_data_t'(rd_data) : stat_s1;
  end

endmodule : cap_bus_slave

`default_nettype wire

// ==== src/cap_top.sv ====
/*
 * Two-channel sample capture buffer, top level.
 * Two credit-controlled streams share one sample RAM through a
 * round-robin arbiter; the CPU reads it over the system bus.
 */

`timescale 1ns/100ps
`default_nettype none

module cap_top (
  input  logic                bus,
  input  logic                ctl_rst,
  // stream channel 0
  input  logic                ch0_str_valid,
  input  cap_pkg::smp_t       ch0_str_data,
  output logic                ch0_str_credit,
  // stream channel 1
  input  logic                ch1_str_valid,
  input  cap_pkg::smp_t       ch1_str_data,
  output logic                ch1_str_credit,
  // system bus
  input  cap_pkg::bus_addr_t  bus_addr,
  input  cap_pkg::bus_data_t  bus_wdata,
  input  logic                bus_wen,
  input  logic                bus_ren,
  output cap_pkg::bus_data_t  bus_rdata,
  output logic                bus_ack,
  output logic                bus_err
);

  // channel to arbiter
  logic               req0, req1, gnt0, gnt1;
  cap_pkg::smp_t      wdata0, wdata1;
  cap_pkg::ram_addr_t waddr0, waddr1;
  // RAM ports
  logic               ram_wen, rd_en;
  cap_pkg::ram_addr_t ram_waddr, rd_addr;
  cap_pkg::smp_t      ram_wdata, rd_data;
  // status and clear
  cap_pkg::seg_addr_t ptr0, ptr1;
  logic               lap0, lap1, clr;

  ////////////////////
  // channels
  ////////////////////

  cap_channel #(.chan(1'b0)) u_ch0 (
    .bus        (bus),
    .ctl_rst    (ctl_rst),
    .str_valid  (ch0_str_valid),
    .str_data   (ch0_str_data),
    .str_credit (ch0_str_credit),
    .req        (req0),
    .gnt        (gnt0),
    .wdata      (wdata0),
    .waddr      (waddr0),
    .clr        (clr),
    .ptr        (ptr0),
    .lap        (lap0)
  );

  cap_channel #(.chan(1'b1)) u_ch1 (
    .bus        (bus),
    .ctl_rst    (ctl_rst),
    .str_valid  (ch1_str_valid),
    .str_data   (ch1_str_data),
    .str_credit (ch1_str_credit),
    .req        (req1),
    .gnt        (gnt1),
    .wdata      (wdata1),
    .waddr      (waddr1),
    .clr        (clr),
    .ptr        (ptr1),
    .lap        (lap1)
  );

  ////////////////////
  // write path
  ////////////////////

  cap_arbiter u_arb (
    .bus       (bus),
    .ctl_rst   (ctl_rst),
    .req0      (req0),
    .wdata0    (wdata0),
    .waddr0    (waddr0),
    .gnt0      (gnt0),
    .req1      (req1),
    .wdata1    (wdata1),
    .waddr1    (waddr1),
    .gnt1      (gnt1),
    .ram_wen   (ram_wen),
    .ram_waddr (ram_waddr),
    .ram_wdata (ram_wdata)
  );

  cap_ram u_ram (
    .bus       (bus),
    .ram_wen   (ram_wen),
    .ram_waddr (ram_waddr),
    .ram_wdata (ram_wdata),
    .rd_en     (rd_en),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data)
  );

  ////////////////////
  // CPU access
  ////////////////////

  cap_bus_slave u_bus (
    .bus       (bus),
    .ctl_rst   (ctl_rst),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .bus_wen   (bus_wen),
    .bus_ren   (bus_ren),
    .bus_rdata (bus_rdata),
    .bus_ack   (bus_ack),
    .bus_err   (bus_err),
    .rd_en     (rd_en),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data),
    .ptr0      (ptr0),
    .ptr1      (ptr1),
    .lap0      (lap0),
    .lap1      (lap1),
    .clr       (clr)
  );

endmodule : cap_top

`default_nettype wire

// ==== dv/cap_tb.sv ====
/*
 * Testbench of the two-channel capture buffer.
 * Credit-honoring sources on both streams, bus reads checked against a
 * reference of the expected samples, and a watchdog.
 */

`timescale 1ns/100ps
`default_nettype none

module cap_tb;

  // rough cycle budget for the whole run
  localparam int n_samples  = 160;
  localparam int n_accesses = 200;
  localparam int run_cycles = n_samples * 6 + n_accesses * 5;
  localparam int seg_words  = 2 ** cap_pkg::seg_aw;

  logic               bus;
  logic               ctl_rst;
  logic               str_valid [2];
  cap_pkg::smp_t      str_data [2];
  logic               str_credit [2];
  cap_pkg::bus_addr_t bus_addr;
  cap_pkg::bus_data_t bus_wdata;
  logic               bus_wen;
  logic               bus_ren;
  cap_pkg::bus_data_t bus_rdata;
  logic               bus_ack;
  logic               bus_err;

  // source bookkeeping per channel
  int     credits [2];
  int     sent [2];
  // samples sent before the last clear
  int     clr_base [2];
  integer seed = 5041;

  // expectation of the access in flight
  cap_pkg::bus_addr_t exp_addr;
  cap_pkg::bus_data_t exp_rdata;
  logic               exp_chk;
  logic               exp_err;
  int                 n_reads;
  int                 n_compared;

  cap_top DUT (
    .bus            (bus),
    .ctl_rst        (ctl_rst),
    .ch0_str_valid  (str_valid[0]),
    .ch0_str_data   (str_data[0]),
    .ch0_str_credit (str_credit[0]),
    .ch1_str_valid  (str_valid[1]),
    .ch1_str_data   (str_data[1]),
    .ch1_str_credit (str_credit[1]),
    .bus_addr       (bus_addr),
    .bus_wdata      (bus_wdata),
    .bus_wen        (bus_wen),
    .bus_ren        (bus_ren),
    .bus_rdata      (bus_rdata),
    .bus_ack        (bus_ack),
    .bus_err        (bus_err)
  );

  always #5 bus = ~bus;

  ////////////////////
  // helpers
  ////////////////////

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Some tests failed");
    $fatal(1, "run stopped at the first error");
  endtask

  // n-th sample of channel c after the last clear
  function automatic cap_pkg::smp_t exp_word(input int c, input int n);
    exp_word = cap_pkg::smp_t'(32'h1000 * c + clr_base[c] + n);
  endfunction

  // byte address of the RAM word that takes sample n
  function automatic cap_pkg::bus_addr_t word_addr(input int c, input int n);
    word_addr = cap_pkg::bus_addr_t'((c * seg_words + n % seg_words) * 4);
  endfunction

  // one source sends count samples and waits for all credits back
  task automatic send_samples(input int c, input int count);
    int left;
    int gap;
    left = count;
    gap = 0;
    do begin
      @(negedge bus);
      str_valid[c] = 1'b0;
      if (str_credit[c]) begin
        credits[c]++;
      end
      assert (credits[c] <= cap_pkg::credit_max)
        else abort_run($sformatf("channel %0d got a credit it never spent", c));
      if (gap > 0) begin
        gap--;
      end else if (left > 0 && credits[c] > 0) begin
        str_valid[c] = 1'b1;
        str_data[c] = cap_pkg::smp_t'(32'h1000 * c + sent[c]);
        sent[c]++;
        credits[c]--;
        left--;
        gap = {$random(seed)} % 4;
      end
    end while (left > 0 || credits[c] != cap_pkg::credit_max);
  endtask

  // one bus access with ack due exactly 2 cycles after the request
  task automatic bus_access(input logic wr, input cap_pkg::bus_addr_t addr,
                            input cap_pkg::bus_data_t wdata, input logic chk,
                            input cap_pkg::bus_data_t exp_data, input logic err);
    int cycles;
    @(negedge bus);
    // expectation for the compare process
    exp_addr = addr;
    exp_rdata = exp_data;
    exp_chk = chk;
    exp_err = err;
    bus_addr = addr;
    bus_wdata = wdata;
    bus_wen = wr;
    bus_ren = ~wr;
    @(negedge bus);
    bus_wen = 1'b0;
    bus_ren = 1'b0;
    cycles = 1;
    while (!bus_ack && cycles < 10) begin
      @(negedge bus);
      cycles++;
    end
    assert (bus_ack && cycles == 2)
      else abort_run($sformatf("access to 0x%03h acknowledged after %0d cycles, not 2",
                               addr, cycles));
  endtask

  task automatic read_check(input cap_pkg::bus_addr_t addr, input cap_pkg::bus_data_t exp);
    n_reads++;
    bus_access(1'b0, addr, '0, 1'b1, exp, 1'b0);
  endtask

  task automatic write_reg(input cap_pkg::bus_addr_t addr, input cap_pkg::bus_data_t data);
    bus_access(1'b1, addr, data, 1'b0, '0, 1'b0);
  endtask

  task automatic check_status(input int c, input int lap, input int ptr);
    read_check(c == 0 ? cap_pkg::adr_ptr0 : cap_pkg::adr_ptr1,
               cap_pkg::bus_data_t'(ptr) | (cap_pkg::bus_data_t'(lap) << 8));
  endtask

  ////////////////////
  // compare
  ////////////////////

  always @(negedge bus) begin
    if (!ctl_rst) begin
      assert (bus_ack || !bus_err)
        else abort_run("bus error raised without an acknowledge");
      if (bus_ack) begin
        assert (bus_err == exp_err)
          else abort_run($sformatf("FAILED at %0d ns: 0x%03h error flag %0b, expected %0b",
                                   $time, exp_addr, bus_err, exp_err));
        if (exp_chk) begin
          n_compared++;
          assert (bus_rdata == exp_rdata)
            else abort_run($sformatf("FAILED at %0d ns: 0x%03h read 0x%08h, expected 0x%08h",
                                     $time, exp_addr, bus_rdata, exp_rdata));
        end
      end
    end
  end

  // watchdog
  initial begin
    #(run_cycles * 10);
    $display("timeout, run still busy after %0d cycles", run_cycles);
    $display("Some tests failed");
    $fatal(1, "watchdog expired");
  end

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    bus = 1'b0;
    ctl_rst = 1'b1;
    bus_addr = '0;
    bus_wdata = '0;
    bus_wen = 1'b0;
    bus_ren = 1'b0;
    exp_addr = '0;
    exp_rdata = '0;
    exp_chk = 1'b0;
    exp_err = 1'b0;
    n_reads = 0;
    n_compared = 0;
    for (int c = 0; c < 2; c++) begin
      str_valid[c] = 1'b0;
      str_data[c] = '0;
      credits[c] = cap_pkg::credit_max;
      sent[c] = 0;
      clr_base[c] = 0;
    end
    repeat (2) @(negedge bus);
    ctl_rst = 1'b0;
    assert (!str_credit[0] && !str_credit[1] && !bus_ack && !bus_err)
      else abort_run("credit or bus outputs not low after reset");

    // status after reset
    check_status(0, 0, 0);
    check_status(1, 0, 0);

    // both channels at once
    fork
      send_samples(0, 40);
      send_samples(1, 40);
    join
    for (int c = 0; c < 2; c++) begin
      for (int n = 0; n < 40; n++) begin
        read_check(word_addr(c, n), cap_pkg::bus_data_t'(exp_word(c, n)));
      end
      check_status(c, 0, 40);
    end

    // software clear then channel 1 restarts at its base
    write_reg(cap_pkg::adr_ctl, 32'h1);
    clr_base[0] = sent[0];
    clr_base[1] = sent[1];
    check_status(0, 0, 0);
    check_status(1, 0, 0);
    send_samples(1, 10);
    for (int n = 0; n < 10; n++) begin
      read_check(word_addr(1, n), cap_pkg::bus_data_t'(exp_word(1, n)));
    end
    check_status(1, 0, 10);

    // channel 0 wraps its segment
    send_samples(0, 70);
    for (int n = 6; n < 70; n++) begin
      read_check(word_addr(0, n), cap_pkg::bus_data_t'(exp_word(0, n)));
    end
    check_status(0, 1, 6);

    // unmapped read errors and a stray RAM write is ignored
    bus_access(1'b0, 12'h20c, '0, 1'b0, '0, 1'b1);
    write_reg(word_addr(0, 64), 32'hffff);
    read_check(word_addr(0, 64), cap_pkg::bus_data_t'(exp_word(0, 64)));
    for (int n = 0; n < 10; n++) begin
      read_check(word_addr(1, n), cap_pkg::bus_data_t'(exp_word(1, n)));
    end
    check_status(0, 1, 6);
    check_status(1, 0, 10);

    @(negedge bus);
    if (n_compared == n_reads) begin
      $display("All tests passed");
      $finish;
    end else begin
      $display("compare process saw %0d of %0d reads", n_compared, n_reads);
      $display("Some tests failed");
      $fatal(1, "read count mismatch");
    end
  end

endmodule : cap_tb

`default_nettype wire

// ==== compile.f ====
src/cap_pkg.sv
src/cap_channel.sv
src/cap_arbiter.sv
src/cap_ram.sv
src/cap_bus_slave.sv
src/cap_top.sv
dv/cap_tb.sv

// ==== Makefile ====
# Verilator simulation of the capture buffer

.PHONY: sim clean

sim:
	verilator --binary --assert --timing --timescale 1ns/100ps -f compile.f \
		--top-module cap_tb -o cap_sim
	@out=$$(./obj_dir/cap_sim); echo "$$out"; echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir
